//--- hdl/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// ##############################
// Datapath sizes
// ##############################

// Bits per line, sixteen 32-bit words
`define WB_LINE_W 512

// Host line address width
`define WB_ADDR_W 42

// Lines held by each on-chip store
`define WB_STORE_DEPTH 64

// ##############################
// Flow control
// ##############################

// Write credits the host grants after reset
`define WB_HOST_CREDITS 4

// Width of every credit counter, room for the host credits plus one
`define WB_CREDIT_W 4

// ##############################
// Register file
// ##############################

`define WB_NUM_REGS 12

`endif

//--- hdl/wb_pkg.sv
`include "wb_config.svh"

package wb_pkg;

    // ##############################
    // Basic types
    // ##############################

    typedef logic [$clog2(`WB_STORE_DEPTH)-1:0] t_line_idx;   // Line index in a store
    typedef logic [`WB_ADDR_W-1:0] t_host_addr;              // Host line address

    // Writeback engine states
    typedef enum logic [1:0]
    {
        IDLE,
        PREPROCESS,
        WRITE,
        DONE
    } t_wb_state;

    // Opcodes written to the CMD register
    typedef enum logic [1:0]
    {
        NOP,
        START,
        ABORT
    } t_wb_cmd;

    // ##############################
    // Register map
    // ##############################

    typedef enum logic [3:0]
    {
        OFF0,           // Index offsets, summed during PREPROCESS
        OFF1,
        OFF2,
        STORE_OFF,      // Bit 31 picks IN_BASE, 30:0 offset
        LENGTH,         // Lines per transfer
        CTRL,           // 3:0 channel, 4 fence, 5 synthetic
        MODEL_START,
        LABEL_START,
        IN_BASE,
        OUT_BASE,
        CMD,            // Write only, decoded to pulses
        STATUS          // Read only, busy and done
    } t_wb_reg;

    // Settings as the engine sees them
    typedef struct packed {
        logic [2:0][31:0] off;
        t_host_addr store_base;   // Selected base plus store offset
        logic [31:0] length;
        logic [3:0] channel;
        logic fence;
        logic synth;
    } t_wb_cfg;

endpackage

//--- hdl/line_stream_if.sv
`include "wb_config.svh"

// Line beats from a store reader to the writeback engine.
// Each credit pulse allows the reader one more beat.
interface line_stream_if;

    logic valid;
    logic [`WB_LINE_W-1:0] data;
    logic last;      // Final line of the reader window
    logic credit;    // One line worth of credit

    modport source
    (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport sink
    (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface

//--- hdl/wb_csr_block.sv
`include "wb_config.svh"

module wb_csr_block
(
    input  logic clk,
    input  logic reset,
    input  logic csr_we,
    input  logic [$clog2(`WB_NUM_REGS)-1:0] csr_addr,
    input  logic [31:0] csr_wdata,
    input  logic done,
    output logic [31:0] csr_rdata,
    output wb_pkg::t_wb_cfg cfg,
    output logic start,
    output logic abort,
    output wb_pkg::t_line_idx model_start_idx,
    output wb_pkg::t_line_idx label_start_idx
);
    import wb_pkg::*;

    logic [31:0] regs [`WB_NUM_REGS];
    logic busy;
    logic done_sticky;
    t_wb_reg reg_sel;
    t_wb_cmd cmd;

    assign reg_sel = t_wb_reg'(csr_addr);
    assign cmd = t_wb_cmd'(csr_wdata[1:0]);

    // ##############################
    // Register writes and command pulses
    // ##############################

    always_ff @(posedge clk)
    begin
        start <= 1'b0;
        abort <= 1'b0;
        if (reset)
        begin
            for (int i = 0; i < `WB_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            busy <= 1'b0;
            done_sticky <= 1'b0;
        end
        else
        begin
            if (csr_we && reg_sel == CMD)
            begin
                case (cmd)
                    START:   start <= 1'b1;
                    ABORT:   abort <= 1'b1;
                    default: ;                       // NOP
                endcase
            end
            else if (csr_we && reg_sel < CMD)
            begin
                regs[csr_addr] <= csr_wdata;
            end

            if (start)
            begin
                busy <= 1'b1;
                done_sticky <= 1'b0;                 // New run clears old done
            end
            else if (done || abort)
            begin
                busy <= 1'b0;
            end
            if (done)
            begin
                done_sticky <= 1'b1;
            end
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk)
    begin
        if (reg_sel == STATUS)
        begin
            csr_rdata <= {30'b0, done_sticky, busy};
        end
        else if (reg_sel < CMD)
        begin
            csr_rdata <= regs[csr_addr];
        end
        else
        begin
            csr_rdata <= '0;                         // CMD and unmapped
        end
    end

    // ##############################
    // Decoded settings
    // ##############################

    always_comb
    begin
        cfg.off[0] = regs[OFF0];
        cfg.off[1] = regs[OFF1];
        cfg.off[2] = regs[OFF2];
        cfg.store_base = (regs[STORE_OFF][31] ? t_host_addr'(regs[IN_BASE])
                                              : t_host_addr'(regs[OUT_BASE]))
                       + t_host_addr'(regs[STORE_OFF][30:0]);
        cfg.length = regs[LENGTH];
        cfg.channel = regs[CTRL][3:0];
        cfg.fence = regs[CTRL][4];
        cfg.synth = regs[CTRL][5];
    end

    assign model_start_idx = t_line_idx'(regs[MODEL_START]);
    assign label_start_idx = t_line_idx'(regs[LABEL_START]);

endmodule

//--- hdl/line_store_reader.sv
`include "wb_config.svh"

module line_store_reader
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic abort,
    input  wb_pkg::t_line_idx start_idx,
    input  logic [31:0] length,
    input  logic load_we,
    input  wb_pkg::t_line_idx load_addr,
    input  logic [`WB_LINE_W-1:0] load_data,
    line_stream_if.source stream
);
    import wb_pkg::*;

    logic [`WB_LINE_W-1:0] mem [`WB_STORE_DEPTH];
    logic [`WB_LINE_W-1:0] rd_q;                  // Memory output register
    logic [31:0] remaining;                       // Lines left to read
    t_line_idx rd_idx;
    logic [`WB_CREDIT_W-1:0] owed;                // Credits not yet answered by a beat
    logic [`WB_CREDIT_W-1:0] held;
    logic [1:0] in_flight;
    logic s1_valid;
    logic s1_last;
    logic issue;

    // ##############################
    // Credit pacing
    // ##############################

    // A read is issued only while credits exceed the beats already under way
    assign held = owed + stream.credit;
    assign in_flight = s1_valid + stream.valid;
    assign issue = (remaining != 0) && (held > in_flight);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remaining <= '0;
            rd_idx <= '0;
            owed <= '0;
            s1_valid <= 1'b0;
            stream.valid <= 1'b0;
            stream.last <= 1'b0;
        end
        else if (start || abort)
        begin
            remaining <= start ? length : 32'd0;    // Abort leaves nothing to read
            rd_idx <= start_idx;
            owed <= '0;
            s1_valid <= 1'b0;
            stream.valid <= 1'b0;
            stream.last <= 1'b0;
        end
        else
        begin
            owed <= held - stream.valid;
            s1_valid <= issue;
            stream.valid <= s1_valid;
            stream.last <= s1_valid && s1_last;
            if (issue)
            begin
                remaining <= remaining - 32'd1;
                rd_idx <= rd_idx + 1'b1;            // Wraps around the store
            end
        end
    end

    // ##############################
    // Line memory
    // ##############################

    always_ff @(posedge clk)
    begin
        if (load_we)
        begin
            mem[load_addr] <= load_data;
        end
        if (issue)
        begin
            rd_q <= mem[rd_idx];
            s1_last <= (remaining == 32'd1);
        end
        if (s1_valid)
        begin
            stream.data <= rd_q;
        end
    end

    // Every beat answers a credit received earlier
    a_valid_has_credit: assert property (@(posedge clk) disable iff (reset)
        stream.valid |-> owed != '0);

endmodule

//--- hdl/wb_engine.sv
`include "wb_config.svh"

module wb_engine
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic abort,
    input  wb_pkg::t_wb_cfg cfg,
    input  logic host_credit,
    input  logic host_ack,
    line_stream_if.sink model_s,
    line_stream_if.sink label_s,
    output logic wr_valid,
    output wb_pkg::t_host_addr wr_addr,
    output logic [`WB_LINE_W-1:0] wr_data,
    output logic done,
    output logic busy
);
    import wb_pkg::*;

    t_wb_state state;

    // Settings captured at start
    logic [2:0][31:0] off;
    t_host_addr base;                             // Accumulates the offsets
    logic [31:0] length;
    logic [3:0] channel;
    logic fence;
    logic synth;

    logic [1:0] acc_idx;
    logic [31:0] granted;                         // Stream credits handed out
    logic [31:0] sent;
    logic [31:0] acked;
    logic [`WB_CREDIT_W-1:0] host_cred;           // Host credits not yet spent
    logic [`WB_CREDIT_W-1:0] reserved;            // Spoken for by stream credits

    logic use_label;
    logic beat_valid;
    logic beat_last;
    logic [`WB_LINE_W-1:0] beat_data;
    logic grant;
    logic accept;
    logic ack_done;

    // ##############################
    // Channel select and credit grant
    // ##############################

    assign use_label = (channel != 4'd0);

    always_comb
    begin
        beat_valid = use_label ? label_s.valid : model_s.valid;
        beat_last = use_label ? label_s.last : model_s.last;
        beat_data = use_label ? label_s.data : model_s.data;
    end

    // Stream credit only against a host credit that nothing else has claimed
    assign grant = (state == WRITE) && (host_cred > reserved) && (granted != length);
    assign model_s.credit = grant && !use_label;
    assign label_s.credit = grant && use_label;

    assign accept = (state == WRITE) && beat_valid;
    assign ack_done = (acked == length) || (host_ack && (acked + 32'd1 == length));

    assign done = (state == DONE);
    assign busy = (state != IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            host_cred <= `WB_HOST_CREDITS;
        end
        else
        begin
            host_cred <= host_cred + host_credit - accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || start || abort)
        begin
            reserved <= '0;
        end
        else
        begin
            reserved <= reserved + grant - accept;
        end
    end

    // ##############################
    // Writeback FSM
    // ##############################

    always_ff @(posedge clk)
    begin
        wr_valid <= 1'b0;
        if (reset || abort)
        begin
            state <= IDLE;                           // Abort leaves no done pulse
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        off <= cfg.off;
                        base <= cfg.store_base;
                        length <= cfg.length;
                        channel <= cfg.channel;
                        fence <= cfg.fence;
                        synth <= cfg.synth;
                        acc_idx <= 2'd0;
                        granted <= '0;
                        sent <= '0;
                        acked <= '0;
                        state <= (cfg.length == 0) ? WRITE : PREPROCESS;
                    end
                end

                PREPROCESS:
                begin
                    base <= base + t_host_addr'(off[acc_idx]);
                    acc_idx <= acc_idx + 2'd1;
                    if (acc_idx == 2'd2)
                    begin
                        state <= WRITE;
                    end
                end

                WRITE:
                begin
                    granted <= granted + 32'(grant);
                    if (accept)
                    begin
                        wr_valid <= 1'b1;
                        wr_addr <= base + t_host_addr'(sent);
                        // Synthetic lines carry the line index in every word
                        wr_data <= synth ? {(`WB_LINE_W/32){sent}} : beat_data;
                        sent <= sent + 32'd1;
                    end
                    if (host_ack)
                    begin
                        acked <= acked + 32'd1;
                    end
                    if (fence ? ack_done : (sent == length))
                    begin
                        state <= DONE;
                    end
                end

                DONE:
                begin
                    state <= IDLE;
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ##############################
    // Checks
    // ##############################

    a_write_needs_credit: assert property (@(posedge clk) disable iff (reset)
        accept |-> host_cred != '0);

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        host_cred <= `WB_HOST_CREDITS);

    // Reader window and engine count must agree on the final line
    a_last_matches_length: assert property (@(posedge clk) disable iff (reset)
        accept && beat_last |-> sent == length - 32'd1);

endmodule

//--- hdl/wb_top.sv
`include "wb_config.svh"

module wb_top
(
    input  logic clk,
    input  logic reset,

    // Register port
    input  logic csr_we,
    input  logic [$clog2(`WB_NUM_REGS)-1:0] csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,

    // Store load port where load_sel high picks the label store
    input  logic load_we,
    input  logic load_sel,
    input  wb_pkg::t_line_idx load_addr,
    input  logic [`WB_LINE_W-1:0] load_data,

    // Host write port
    output logic wr_valid,
    output logic [`WB_ADDR_W-1:0] wr_addr,
    output logic [`WB_LINE_W-1:0] wr_data,
    input  logic host_credit,
    input  logic host_ack
);
    import wb_pkg::*;

    t_wb_cfg cfg;
    logic start;
    logic abort;
    logic done;
    t_line_idx model_start_idx;
    t_line_idx label_start_idx;

    line_stream_if model_s ();
    line_stream_if label_s ();

    wb_csr_block u_csr (
        .clk,
        .reset,
        .csr_we,
        .csr_addr,
        .csr_wdata,
        .done,
        .csr_rdata,
        .cfg,
        .start,
        .abort,
        .model_start_idx,
        .label_start_idx
    );

    // ##############################
    // Line stores
    // ##############################

    line_store_reader u_model_reader (
        .clk,
        .reset,
        .start,
        .abort,
        .start_idx (model_start_idx),
        .length    (cfg.length),
        .load_we   (load_we && !load_sel),
        .load_addr,
        .load_data,
        .stream    (model_s.source)
    );

    line_store_reader u_label_reader (
        .clk,
        .reset,
        .start,
        .abort,
        .start_idx (label_start_idx),
        .length    (cfg.length),
        .load_we   (load_we && load_sel),
        .load_addr,
        .load_data,
        .stream    (label_s.source)
    );

    wb_engine u_engine (
        .clk,
        .reset,
        .start,
        .abort,
        .cfg,
        .host_credit,
        .host_ack,
        .model_s (model_s.sink),
        .label_s (label_s.sink),
        .wr_valid,
        .wr_addr,
        .wr_data,
        .done,
        .busy    ()
    );

endmodule

//--- sim/wb_tb.sv
`include "wb_config.svh"

module wb_tb;
    import wb_pkg::*;

    // Transfer lengths that also size the timeout
    localparam int LEN_COPY = 12;
    localparam int LEN_SYNTH = 10;
    localparam int LEN_FENCE = 6;
    localparam int LEN_BP = 20;
    localparam int LEN_ABORT = 40;
    localparam int LEN_RESTART = 5;
    localparam int TOTAL_LINES = LEN_COPY + LEN_SYNTH + LEN_FENCE + LEN_BP + LEN_ABORT
                               + LEN_RESTART;
    localparam int CYCLES_PER_LINE = 60;                     // Sparse credits and acks
    localparam int SETUP_CYCLES = 4 * `WB_STORE_DEPTH + 1000;
    localparam int TIMEOUT_CYCLES = TOTAL_LINES * CYCLES_PER_LINE + SETUP_CYCLES;

    logic clk;
    logic reset;
    logic csr_we;
    logic [$clog2(`WB_NUM_REGS)-1:0] csr_addr;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic load_we;
    logic load_sel;
    logic [$clog2(`WB_STORE_DEPTH)-1:0] load_addr;
    logic [`WB_LINE_W-1:0] load_data;
    logic wr_valid;
    logic [`WB_ADDR_W-1:0] wr_addr;
    logic [`WB_LINE_W-1:0] wr_data;
    logic host_credit;
    logic host_ack;

    logic [31:0] reg_shadow [`WB_NUM_REGS];       // Last value written to each register
    logic [`WB_ADDR_W-1:0] got_addr [$];
    logic [`WB_LINE_W-1:0] got_data [$];
    int credits_owed;                             // Writes seen without a returned credit
    int acks_owed;
    int credit_pct;
    int ack_pct;
    logic hold_acks;
    logic give_credit;
    logic give_ack;
    int cycle_count = 0;

    wb_top u_dut (
        .clk,
        .reset,
        .csr_we,
        .csr_addr,
        .csr_wdata,
        .csr_rdata,
        .load_we,
        .load_sel,
        .load_addr,
        .load_data,
        .wr_valid,
        .wr_addr,
        .wr_data,
        .host_credit,
        .host_ack
    );

    always #4 clk = ~clk;

    // ##############################
    // Checks and reference model
    // ##############################

    task automatic check_value(string name, logic [`WB_LINE_W-1:0] got,
                               logic [`WB_LINE_W-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Preload pattern tagging every word with store, address and word index
    function automatic logic [`WB_LINE_W-1:0] line_pattern(int sel, int addr);
        logic [`WB_LINE_W-1:0] line;
        for (int w = 0; w < `WB_LINE_W / 32; w++)
        begin
            line[w*32 +: 32] = {(sel != 0) ? 8'hb1 : 8'ha1, 2'b00, 6'(addr), 4'(w),
                                12'(addr * 37 + w)};
        end
        return line;
    endfunction

    function automatic logic [`WB_ADDR_W-1:0] expected_addr(int idx);
        logic [`WB_ADDR_W-1:0] addr;
        addr = reg_shadow[STORE_OFF][31] ? `WB_ADDR_W'(reg_shadow[IN_BASE])
                                         : `WB_ADDR_W'(reg_shadow[OUT_BASE]);
        addr = addr + `WB_ADDR_W'(reg_shadow[STORE_OFF][30:0]);
        addr = addr + `WB_ADDR_W'(reg_shadow[OFF0]) + `WB_ADDR_W'(reg_shadow[OFF1])
             + `WB_ADDR_W'(reg_shadow[OFF2]);
        return addr + `WB_ADDR_W'(idx);
    endfunction

    function automatic logic [`WB_LINE_W-1:0] expected_data(int idx);
        logic [31:0] word;
        word = idx;
        if (reg_shadow[CTRL][5])
        begin
            return {(`WB_LINE_W / 32){word}};                // Synthetic fill
        end
        if (reg_shadow[CTRL][3:0] != 4'd0)
        begin
            return line_pattern(1, (reg_shadow[LABEL_START] + idx) % `WB_STORE_DEPTH);
        end
        return line_pattern(0, (reg_shadow[MODEL_START] + idx) % `WB_STORE_DEPTH);
    endfunction

    // ##############################
    // Host model and write monitor
    // ##############################

    initial
    begin
        void'($urandom(32'h88a8));
        forever
        begin
            @(posedge clk);
            if (reset)
            begin
                host_credit <= 1'b0;
                host_ack <= 1'b0;
                credits_owed = 0;
                acks_owed = 0;
            end
            else
            begin
                give_credit = (credits_owed > 0) && (($urandom % 100) < credit_pct);
                give_ack = !hold_acks && (acks_owed > 0) && (($urandom % 100) < ack_pct);
                if (wr_valid)
                begin
                    got_addr.push_back(wr_addr);
                    got_data.push_back(wr_data);
                end
                credits_owed = credits_owed + int'(wr_valid) - int'(give_credit);
                acks_owed = acks_owed + int'(wr_valid) - int'(give_ack);
                host_credit <= give_credit;
                host_ack <= give_ack;
                check_value("outstanding_over_limit", credits_owed > `WB_HOST_CREDITS, 0);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // ##############################
    // Bus helpers
    // ##############################

    task automatic csr_write(t_wb_reg addr, logic [31:0] data);
        @(posedge clk);
        csr_we <= 1'b1;
        csr_addr <= addr;
        csr_wdata <= data;
        if (addr < CMD)
        begin
            reg_shadow[addr] = data;
        end
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic csr_read(t_wb_reg addr, output logic [31:0] data);
        @(posedge clk);
        csr_addr <= addr;
        @(posedge clk);
        @(negedge clk);                                      // Registered read data
        data = csr_rdata;
    endtask

    task automatic load_stores();
        for (int s = 0; s < 2; s++)
        begin
            for (int a = 0; a < `WB_STORE_DEPTH; a++)
            begin
                @(posedge clk);
                load_we <= 1'b1;
                load_sel <= s[0];
                load_addr <= a;
                load_data <= line_pattern(s, a);
            end
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic configure(logic [31:0] store_off, int length, logic [31:0] ctrl,
                             int model_start, int label_start);
        csr_write(OFF0, 32'h3);
        csr_write(OFF1, 32'h10);
        csr_write(OFF2, 32'h100);
        csr_write(STORE_OFF, store_off);
        csr_write(LENGTH, length);
        csr_write(CTRL, ctrl);
        csr_write(MODEL_START, model_start);
        csr_write(LABEL_START, label_start);
    endtask

    task automatic set_host_rates(int credit_rate, int ack_rate);
        @(posedge clk);
        credit_pct <= credit_rate;
        ack_pct <= ack_rate;
    endtask

    task automatic start_transfer();
        got_addr.delete();
        got_data.delete();
        csr_write(CMD, 32'(START));
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[1])
        begin
            csr_read(STATUS, status);
        end
    endtask

    task automatic wait_host_idle();
        while (credits_owed != 0 || acks_owed != 0)
        begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic verify_lines(int count);
        for (int i = 0; i < count; i++)
        begin
            check_value($sformatf("wr_addr[%0d]", i), got_addr[i], expected_addr(i));
            check_value($sformatf("wr_data[%0d]", i), got_data[i], expected_data(i));
        end
    endtask

    task automatic run_and_verify(int length);
        start_transfer();
        wait_done();
        wait_host_idle();
        check_value("write_count", got_addr.size(), length);
        verify_lines(length);
    endtask

    // ##############################
    // Directed tests
    // ##############################

    task automatic copy_model_channel();
        set_host_rates(60, 60);
        configure(32'h2000, LEN_COPY, 32'h0, 5, 0);
        run_and_verify(LEN_COPY);
    endtask

    task automatic label_synthetic();
        set_host_rates(60, 60);
        configure(32'h8000_0040, LEN_SYNTH, 32'h21, 0, 20);   // Synthetic label lines
        run_and_verify(LEN_SYNTH);
    endtask

    task automatic fence_on_acks();
        logic [31:0] status;
        set_host_rates(100, 100);
        @(posedge clk);
        hold_acks <= 1'b1;
        configure(32'h0, LEN_FENCE, 32'h10, 40, 0);
        start_transfer();
        while (got_addr.size() < LEN_FENCE)
        begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);                          // Acks still withheld
        csr_read(STATUS, status);
        check_value("status_fence_wait", status, 32'h1);
        @(posedge clk);
        hold_acks <= 1'b0;
        wait_done();
        check_value("acks_owed_at_done", acks_owed, 0);
        csr_read(STATUS, status);
        check_value("status_fence_done", status, 32'h2);
        wait_host_idle();
        check_value("write_count", got_addr.size(), LEN_FENCE);
        verify_lines(LEN_FENCE);
    endtask

    task automatic back_pressure();
        set_host_rates(15, 30);
        configure(32'h0000_0400, LEN_BP, 32'h1, 0, 30);
        run_and_verify(LEN_BP);
    endtask

    task automatic zero_length_and_abort();
        logic [31:0] status;
        int seen;
        set_host_rates(100, 100);
        configure(32'h0, 0, 32'h0, 0, 0);
        run_and_verify(0);
        set_host_rates(10, 100);
        configure(32'h100, LEN_ABORT, 32'h0, 10, 0);
        start_transfer();
        while (got_addr.size() < 3)
        begin
            @(posedge clk);
        end
        csr_write(CMD, 32'(ABORT));
        repeat (2) @(posedge clk);
        seen = got_addr.size();
        repeat (20) @(posedge clk);
        check_value("writes_after_abort", got_addr.size(), seen);
        csr_read(STATUS, status);
        check_value("status_after_abort", status, 32'h0);    // Neither busy nor done
        set_host_rates(100, 100);
        wait_host_idle();
        verify_lines(seen);
        configure(32'h100, LEN_RESTART, 32'h0, 50, 0);
        run_and_verify(LEN_RESTART);
    endtask

    initial
    begin
        logic [31:0] status;
        clk = 1'b0;
        reset = 1'b1;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        load_we = 1'b0;
        load_sel = 1'b0;
        load_addr = '0;
        load_data = '0;
        host_credit = 1'b0;
        host_ack = 1'b0;
        hold_acks = 1'b0;
        credit_pct = 100;
        ack_pct = 100;
        for (int i = 0; i < `WB_NUM_REGS; i++)
        begin
            reg_shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("wr_valid", wr_valid, 0);
        csr_read(STATUS, status);
        check_value("status_after_reset", status, 32'h0);

        load_stores();
        csr_write(IN_BASE, 32'h4000_0000);
        csr_write(OUT_BASE, 32'h8000_0000);

        copy_model_channel();
        label_synthetic();
        fence_on_acks();
        back_pressure();
        zero_length_and_abort();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/line_stream_if.sv
hdl/wb_csr_block.sv
hdl/line_store_reader.sv
hdl/wb_engine.sv
hdl/wb_top.sv
sim/wb_tb.sv

//--- Bender.yml
package:
  name: line_writeback

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_pkg.sv
      - hdl/line_stream_if.sv
      - hdl/wb_csr_block.sv
      - hdl/line_store_reader.sv
      - hdl/wb_engine.sv
      - hdl/wb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/wb_tb.sv
